// ==== verilog/safe_defs.svh ====
//************************************************
// Hart count, bus widths and the read values
// returned to an isolated hart
//************************************************

`ifndef SAFE_DEFS_SVH
`define SAFE_DEFS_SVH

// Three harts, the voter is three-way
`define SAFE_NHARTS 3

// Bus geometry
`define SAFE_ADDR_W 32
`define SAFE_DATA_W 32
`define SAFE_BE_W 4

// Isolated instruction bus returns wfi
`define SAFE_WFI_INSTR 32'h10500073
// Isolated data bus returns zero
`define SAFE_ISO_DATA 32'h00000000

`endif

// ==== verilog/safe_pkg.sv ====
//************************************************
// Bus request and response bundles, safe mode
// encoding and configuration word
//************************************************

`default_nettype none

`include "safe_defs.svh"

package safe_pkg;

  // One bit per hart
  typedef logic [`SAFE_NHARTS-1:0] hart_mask_t;

  // Hart to memory, 70 bits
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`SAFE_BE_W-1:0]   be;
    logic [`SAFE_ADDR_W-1:0] addr;
    logic [`SAFE_DATA_W-1:0] wdata;
  } bus_req_t;

  // Memory to hart, 34 bits
  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic [`SAFE_DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_TMR    = 2'd1,
    MODE_DMR    = 2'd2
  } safe_mode_e;

  // Master is one-hot, dmr_pair holds master plus partner
  typedef struct packed {
    safe_mode_e mode;
    hart_mask_t master;
    hart_mask_t dmr_pair;
  } safe_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/safe_mode_ctrl.sv ====
//************************************************
// Active safe configuration register with the
// sleep-gated update and the isolation mask
//************************************************

`timescale 1ns/1ps
`default_nettype none

module safe_mode_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  safe_pkg::hart_mask_t sleep_i,
  input  safe_pkg::safe_cfg_t  cfg_i,
  input  logic                 cfg_valid_i,
  output safe_pkg::safe_cfg_t  cfg_o,
  output safe_pkg::hart_mask_t isolate_o
);

  import safe_pkg::*;

  // Single mode, hart 0 as master, pair 0 and 1
  localparam safe_cfg_t CfgReset = '{
    mode:     MODE_SINGLE,
    master:   hart_mask_t'(1),
    dmr_pair: hart_mask_t'(3)
  };

  safe_cfg_t cfg_q;
  logic      all_sleep;

  // Mode changes only with every hart parked in wfi
  assign all_sleep = &sleep_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= CfgReset;
    end else if (cfg_valid_i && all_sleep) begin
      cfg_q <= cfg_i;
    end
  end

  assign cfg_o = cfg_q;

  // Hart outside the lockstep pair is cut off the bus
  always_comb begin
    if (cfg_q.mode == MODE_DMR) begin
      isolate_o = ~cfg_q.dmr_pair;
    end else begin
      isolate_o = '0;
    end
  end

  // Routers pick the master port from this mask
  a_master_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot(cfg_q.master)
  ) else $error("master mask is not one-hot");

  // Exactly one partner beside the master in lockstep
  a_dmr_pair: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cfg_q.mode == MODE_DMR) |->
      (($countones(cfg_q.dmr_pair) == 2) && |(cfg_q.dmr_pair & cfg_q.master))
  ) else $error("dmr pair does not hold master plus one partner");

endmodule

`default_nettype wire

// ==== verilog/tmr_voter.sv ====
//************************************************
// Bitwise majority voter over three requests
// with mismatch flag and disagreeing harts
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "safe_defs.svh"

module tmr_voter (
  input  logic                                    enable_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  req_i,
  output safe_pkg::bus_req_t                     voted_o,
  output logic                                    error_o,
  output safe_pkg::hart_mask_t                   error_id_o
);

  import safe_pkg::*;

  bus_req_t   majority;
  hart_mask_t differs;

  // Two out of three per bit
  assign majority = (req_i[0] & req_i[1]) |
                    (req_i[1] & req_i[2]) |
                    (req_i[0] & req_i[2]);

  for (genvar i = 0; i < `SAFE_NHARTS; i++) begin : gen_differs
    assign differs[i] = (req_i[i] != majority);
  end

  // Everything quiet outside TMR mode
  always_comb begin
    if (enable_i) begin
      voted_o    = majority;
      error_o    = |differs;
      error_id_o = differs;
    end else begin
      voted_o    = '0;
      error_o    = 1'b0;
      error_id_o = '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dmr_comparator.sv ====
//************************************************
// Lockstep comparator of master and partner
// requests
//************************************************

`timescale 1ns/1ps
`default_nettype none

module dmr_comparator (
  input  logic               enable_i,
  input  safe_pkg::bus_req_t master_req_i,
  input  safe_pkg::bus_req_t partner_req_i,
  output safe_pkg::bus_req_t req_o,
  output logic               error_o
);

  import safe_pkg::*;

  bus_req_t req_diff;

  // Master drives the shared port
  assign req_o = master_req_i;

  // Any differing bit counts as a lockstep fault
  assign req_diff = master_req_i ^ partner_req_i;
  assign error_o  = enable_i && (|req_diff);

endmodule

`default_nettype wire

// ==== verilog/bus_isolator.sv ====
//************************************************
// Local responder for an isolated hart with
// flush of a response still owed by memory
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "safe_defs.svh"

module bus_isolator #(
  parameter logic [`SAFE_DATA_W-1:0] RDATA = `SAFE_ISO_DATA
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               isolate_i,
  input  safe_pkg::bus_req_t hart_req_i,
  input  safe_pkg::bus_rsp_t mem_rsp_i,
  output safe_pkg::bus_rsp_t rsp_o
);

  import safe_pkg::*;

  logic iso_rvalid_q;
  logic pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iso_rvalid_q <= 1'b0;
      pending_q    <= 1'b0;
    end else if (!isolate_i) begin
      iso_rvalid_q <= 1'b0;
      // Accepted by memory and not answered yet
      pending_q    <= (hart_req_i.req && mem_rsp_i.gnt) ||
                      (pending_q && !mem_rsp_i.rvalid);
    end else begin
      // Every local grant answers one cycle later
      iso_rvalid_q <= hart_req_i.req;
      pending_q    <= 1'b0;
    end
  end

  // Owed response is released in the first isolated cycle
  assign rsp_o.gnt    = hart_req_i.req;
  assign rsp_o.rvalid = iso_rvalid_q | pending_q;
  assign rsp_o.rdata  = RDATA;

endmodule

`default_nettype wire

// ==== verilog/bus_router.sv ====
//************************************************
// Per-bus request steering onto memory ports and
// response fan-back to the harts
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "safe_defs.svh"

module bus_router (
  input  safe_pkg::safe_cfg_t                    cfg_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  hart_req_i,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  mem_rsp_i,
  input  safe_pkg::bus_req_t                     voted_req_i,
  input  safe_pkg::bus_req_t                     compared_req_i,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  iso_rsp_i,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  mem_req_o,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  hart_rsp_o,
  output safe_pkg::bus_req_t                     master_req_o,
  output safe_pkg::bus_req_t                     partner_req_o
);

  import safe_pkg::*;

  hart_mask_t partner;
  bus_rsp_t   master_rsp;

  // Pair member that is not the master
  assign partner = cfg_i.dmr_pair & ~cfg_i.master;

  // One-hot selects for the comparator inputs and the shared response
  always_comb begin
    master_req_o  = '0;
    partner_req_o = '0;
    master_rsp    = '0;
    for (int i = 0; i < `SAFE_NHARTS; i++) begin
      if (cfg_i.master[i]) begin
        master_req_o = hart_req_i[i];
        master_rsp   = mem_rsp_i[i];
      end
      if (partner[i]) begin
        partner_req_o = hart_req_i[i];
      end
    end
  end

  // Memory side, only the master port is live in redundant modes
  always_comb begin
    for (int i = 0; i < `SAFE_NHARTS; i++) begin
      case (cfg_i.mode)
        MODE_TMR: begin
          mem_req_o[i] = cfg_i.master[i] ? voted_req_i : '0;
        end
        MODE_DMR: begin
          mem_req_o[i] = cfg_i.master[i] ? compared_req_i : '0;
        end
        default: begin
          mem_req_o[i] = hart_req_i[i];
        end
      endcase
    end
  end

  // Hart side
  always_comb begin
    for (int i = 0; i < `SAFE_NHARTS; i++) begin
      case (cfg_i.mode)
        MODE_TMR: begin
          hart_rsp_o[i] = master_rsp;
        end
        MODE_DMR: begin
          // Unpaired hart talks to its local responder
          hart_rsp_o[i] = cfg_i.dmr_pair[i] ? master_rsp : iso_rsp_i[i];
        end
        default: begin
          hart_rsp_o[i] = mem_rsp_i[i];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/safe_bus_wrapper.sv ====
//************************************************
// Triple-hart safety bus wrapper top level with
// control, routing, voting and isolation per bus
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "safe_defs.svh"

module safe_bus_wrapper (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Hart side
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  hart_instr_req_i,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  hart_instr_rsp_o,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  hart_data_req_i,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  hart_data_rsp_o,
  // Memory side
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  mem_instr_req_o,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  mem_instr_rsp_i,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0]  mem_data_req_o,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0]  mem_data_rsp_i,
  // Configuration and status
  input  safe_pkg::hart_mask_t                   sleep_i,
  input  safe_pkg::safe_cfg_t                    cfg_i,
  input  logic                                    cfg_valid_i,
  output logic                                    tmr_error_o,
  output logic                                    dmr_error_o,
  output safe_pkg::hart_mask_t                   tmr_error_id_o
);

  import safe_pkg::*;

  // Bus 0 is instruction, bus 1 is data
  localparam int NBUS = 2;

  safe_cfg_t  cfg;
  hart_mask_t isolate;
  logic       tmr_en;
  logic       dmr_en;

  bus_req_t   [NBUS-1:0][`SAFE_NHARTS-1:0] hart_req;
  bus_rsp_t   [NBUS-1:0][`SAFE_NHARTS-1:0] hart_rsp;
  bus_req_t   [NBUS-1:0][`SAFE_NHARTS-1:0] mem_req;
  bus_rsp_t   [NBUS-1:0][`SAFE_NHARTS-1:0] mem_rsp;
  bus_rsp_t   [NBUS-1:0][`SAFE_NHARTS-1:0] iso_rsp;
  bus_req_t   [NBUS-1:0]                   voted_req;
  bus_req_t   [NBUS-1:0]                   master_req;
  bus_req_t   [NBUS-1:0]                   partner_req;
  bus_req_t   [NBUS-1:0]                   compared_req;
  logic       [NBUS-1:0]                   tmr_err;
  logic       [NBUS-1:0]                   dmr_err;
  hart_mask_t [NBUS-1:0]                   tmr_err_id;

  assign hart_req[0]      = hart_instr_req_i;
  assign hart_req[1]      = hart_data_req_i;
  assign mem_rsp[0]       = mem_instr_rsp_i;
  assign mem_rsp[1]       = mem_data_rsp_i;
  assign hart_instr_rsp_o = hart_rsp[0];
  assign hart_data_rsp_o  = hart_rsp[1];
  assign mem_instr_req_o  = mem_req[0];
  assign mem_data_req_o   = mem_req[1];

  safe_mode_ctrl safe_mode_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sleep_i     (sleep_i),
    .cfg_i       (cfg_i),
    .cfg_valid_i (cfg_valid_i),
    .cfg_o       (cfg),
    .isolate_o   (isolate)
  );

  assign tmr_en = (cfg.mode == MODE_TMR);
  assign dmr_en = (cfg.mode == MODE_DMR);

  for (genvar b = 0; b < NBUS; b++) begin : gen_bus
    localparam logic [`SAFE_DATA_W-1:0] IsoRdata =
      (b == 0) ? `SAFE_WFI_INSTR : `SAFE_ISO_DATA;

    bus_router bus_router_inst (
      .cfg_i          (cfg),
      .hart_req_i     (hart_req[b]),
      .mem_rsp_i      (mem_rsp[b]),
      .voted_req_i    (voted_req[b]),
      .compared_req_i (compared_req[b]),
      .iso_rsp_i      (iso_rsp[b]),
      .mem_req_o      (mem_req[b]),
      .hart_rsp_o     (hart_rsp[b]),
      .master_req_o   (master_req[b]),
      .partner_req_o  (partner_req[b])
    );

    tmr_voter tmr_voter_inst (
      .enable_i   (tmr_en),
      .req_i      (hart_req[b]),
      .voted_o    (voted_req[b]),
      .error_o    (tmr_err[b]),
      .error_id_o (tmr_err_id[b])
    );

    dmr_comparator dmr_comparator_inst (
      .enable_i      (dmr_en),
      .master_req_i  (master_req[b]),
      .partner_req_i (partner_req[b]),
      .req_o         (compared_req[b]),
      .error_o       (dmr_err[b])
    );

    // Isolators watch the response each hart actually receives
    for (genvar h = 0; h < `SAFE_NHARTS; h++) begin : gen_iso
      bus_isolator #(
        .RDATA (IsoRdata)
      ) bus_isolator_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .isolate_i  (isolate[h]),
        .hart_req_i (hart_req[b][h]),
        .mem_rsp_i  (hart_rsp[b][h]),
        .rsp_o      (iso_rsp[b][h])
      );
    end
  end

  assign tmr_error_o    = |tmr_err;
  assign dmr_error_o    = |dmr_err;
  assign tmr_error_id_o = tmr_err_id[0] | tmr_err_id[1];

endmodule

`default_nettype wire

// ==== tests/tb_safe_bus_wrapper.sv ====
//************************************************
// Testbench for the safety bus wrapper: random
// harts, memory model, reference model, watchdog
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "safe_defs.svh"

module tb_safe_bus_wrapper;

  import safe_pkg::*;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_CYCLES  = 200;
  localparam int SHORT_CYCLES = 20;
  localparam int DRAIN_MAX    = 20;
  localparam int NUM_CFG      = 6;
  localparam int CMP_W        = $bits(bus_req_t);
  localparam int TOTAL_CYCLES = RESET_CYCLES + RAND_CYCLES +
    NUM_CFG * (2 * (DRAIN_MAX + 3) + 4 + SHORT_CYCLES + RAND_CYCLES);
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * PERIOD;

  logic                             clk;
  logic                             rst_n;
  bus_req_t [1:0][`SAFE_NHARTS-1:0] hart_req;
  wire bus_rsp_t [1:0][`SAFE_NHARTS-1:0] hart_rsp;
  wire bus_req_t [1:0][`SAFE_NHARTS-1:0] mem_req;
  bus_rsp_t [1:0][`SAFE_NHARTS-1:0] mem_rsp = '0;
  hart_mask_t                       sleep;
  safe_cfg_t                        cfg_in;
  logic                             cfg_valid;
  wire logic                        tmr_error;
  wire logic                        dmr_error;
  wire hart_mask_t                  tmr_error_id;

  // Reference model state
  safe_cfg_t                        cfg_m;
  logic [1:0][`SAFE_NHARTS-1:0]     iso_rv_exp;
  // Per port rvalid schedule, bit 0 is the coming cycle
  logic [2:0]                       sched [0:1][0:`SAFE_NHARTS-1];
  logic                             checking;
  int                               fail_count;
  safe_cfg_t                        cfg_list [NUM_CFG];

  always #(PERIOD / 2) clk = ~clk;

  safe_bus_wrapper safe_bus_wrapper_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .hart_instr_req_i (hart_req[0]),
    .hart_instr_rsp_o (hart_rsp[0]),
    .hart_data_req_i  (hart_req[1]),
    .hart_data_rsp_o  (hart_rsp[1]),
    .mem_instr_req_o  (mem_req[0]),
    .mem_instr_rsp_i  (mem_rsp[0]),
    .mem_data_req_o   (mem_req[1]),
    .mem_data_rsp_i   (mem_rsp[1]),
    .sleep_i          (sleep),
    .cfg_i            (cfg_in),
    .cfg_valid_i      (cfg_valid),
    .tmr_error_o      (tmr_error),
    .dmr_error_o      (dmr_error),
    .tmr_error_id_o   (tmr_error_id)
  );

  function automatic safe_cfg_t make_cfg(safe_mode_e mode, int master, int partner);
    safe_cfg_t c;
    c.mode     = mode;
    c.master   = hart_mask_t'(1 << master);
    c.dmr_pair = hart_mask_t'((1 << master) | (1 << partner));
    return c;
  endfunction

  function automatic bus_req_t random_req();
    logic [95:0] bits;
    bits = {$urandom, $urandom, $urandom};
    return bus_req_t'(bits[CMP_W-1:0]);
  endfunction

  // Two of the three always agree, only one hart is ever faulted
  function automatic bus_req_t agreed_req(bus_req_t a, bus_req_t b, bus_req_t c);
    if (a == b || a == c) return a;
    return b;
  endfunction

  function automatic logic memory_busy();
    logic busy;
    busy = 1'b0;
    for (int b = 0; b < 2; b++) begin
      for (int h = 0; h < `SAFE_NHARTS; h++) busy = busy | (|sched[b][h]);
    end
    return busy;
  endfunction

  task automatic compare_value(input string name, input logic [CMP_W-1:0] actual,
                               input logic [CMP_W-1:0] expected);
    if (actual !== expected) begin
      fail_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Sleep-gated configuration and the isolated responder
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_m      <= make_cfg(MODE_SINGLE, 0, 1);
      iso_rv_exp <= '0;
    end else begin
      if (cfg_valid && (&sleep)) cfg_m <= cfg_in;
      for (int b = 0; b < 2; b++) begin
        for (int h = 0; h < `SAFE_NHARTS; h++) begin
          iso_rv_exp[b][h] <= (cfg_m.mode == MODE_DMR) && !cfg_m.dmr_pair[h] &&
                              hart_req[b][h].req;
        end
      end
    end
  end

  // Memory answers in order-free slots one to three cycles after acceptance
  always @(posedge clk) begin : mem_model
    logic [2:0] s;
    int         d;
    for (int b = 0; b < 2; b++) begin
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        if (!rst_n) begin
          sched[b][h]   <= '0;
          mem_rsp[b][h] <= '0;
        end else begin
          s = sched[b][h] >> 1;
          if (mem_req[b][h].req && mem_rsp[b][h].gnt) begin
            d = int'($urandom % 3);
            while (d < 2 && s[d]) d++;
            s[d] = 1'b1;
          end
          sched[b][h]          <= s;
          mem_rsp[b][h].gnt    <= ($urandom % 4) != 0;
          mem_rsp[b][h].rvalid <= s[0];
          mem_rsp[b][h].rdata  <= $urandom;
        end
      end
    end
  end

  task automatic check_outputs();
    bus_req_t   exp_req;
    bus_rsp_t   exp_rsp;
    bus_req_t   voted;
    hart_mask_t partner;
    hart_mask_t id_exp;
    logic       dmr_exp;
    int         m;
    int         p;
    m       = 0;
    p       = 0;
    id_exp  = '0;
    dmr_exp = 1'b0;
    partner = cfg_m.dmr_pair & ~cfg_m.master;
    for (int h = 0; h < `SAFE_NHARTS; h++) begin
      if (cfg_m.master[h]) m = h;
      if (partner[h]) p = h;
    end
    for (int b = 0; b < 2; b++) begin
      voted = agreed_req(hart_req[b][0], hart_req[b][1], hart_req[b][2]);
      if (cfg_m.mode == MODE_DMR && hart_req[b][p] != hart_req[b][m]) dmr_exp = 1'b1;
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        exp_req = '0;
        case (cfg_m.mode)
          MODE_TMR: begin
            if (h == m) exp_req = voted;
            exp_rsp = mem_rsp[b][m];
            if (hart_req[b][h] != voted) id_exp[h] = 1'b1;
          end
          MODE_DMR: begin
            if (h == m) exp_req = hart_req[b][m];
            if (cfg_m.dmr_pair[h]) begin
              exp_rsp = mem_rsp[b][m];
            end else begin
              exp_rsp.gnt    = hart_req[b][h].req;
              exp_rsp.rvalid = iso_rv_exp[b][h];
              exp_rsp.rdata  = (b == 0) ? `SAFE_WFI_INSTR : `SAFE_ISO_DATA;
            end
          end
          default: begin
            exp_req = hart_req[b][h];
            exp_rsp = mem_rsp[b][h];
          end
        endcase
        compare_value($sformatf("mem_%s_req_o[%0d]", b ? "data" : "instr", h),
                      CMP_W'(mem_req[b][h]), CMP_W'(exp_req));
        compare_value($sformatf("hart_%s_rsp_o[%0d]", b ? "data" : "instr", h),
                      CMP_W'(hart_rsp[b][h]), CMP_W'(exp_rsp));
      end
    end
    compare_value("tmr_error_o", CMP_W'(tmr_error), CMP_W'(|id_exp));
    compare_value("dmr_error_o", CMP_W'(dmr_error), CMP_W'(dmr_exp));
    compare_value("tmr_error_id_o", CMP_W'(tmr_error_id), CMP_W'(id_exp));
  endtask

  always @(negedge clk) begin
    if (checking) check_outputs();
  end

  // Redundant harts share one request, now and then one is corrupted
  task automatic drive_requests();
    bus_req_t base;
    bus_req_t r;
    int       victim;
    for (int b = 0; b < 2; b++) begin
      base   = random_req();
      victim = (($urandom % 8) == 0) ? int'($urandom % 3) : -1;
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        r = (cfg_m.mode == MODE_SINGLE) ? random_req() : base;
        // Flip below the req bit so the handshake stays common
        if (h == victim) r = r ^ (CMP_W'(1) << ($urandom % (CMP_W - 1)));
        hart_req[b][h] <= r;
      end
    end
  endtask

  task automatic run_random(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      drive_requests();
    end
  endtask

  task automatic drain_memory();
    int waited;
    @(posedge clk);
    hart_req <= '0;
    waited = 0;
    @(negedge clk);
    while (memory_busy() && waited < DRAIN_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (memory_busy()) begin
      $display("Memory model still owes responses after %0d idle cycles", DRAIN_MAX);
      $display("TESTS FAILED");
      $fatal(1, "Memory did not drain");
    end
  endtask

  task automatic apply_config(input safe_cfg_t c, input logic all_asleep);
    @(posedge clk);
    cfg_in    <= c;
    cfg_valid <= 1'b1;
    if (all_asleep) sleep <= '1;
    else sleep <= hart_mask_t'($urandom % 7);
    @(posedge clk);
    cfg_valid <= 1'b0;
    sleep     <= '0;
  endtask

  initial begin
    void'($urandom(54362));
    clk        = 1'b0;
    rst_n      = 1'b0;
    hart_req   = '0;
    sleep      = '0;
    cfg_in     = '0;
    cfg_valid  = 1'b0;
    checking   = 1'b0;
    fail_count = 0;
    cfg_list[0] = make_cfg(MODE_TMR, 0, 1);
    cfg_list[1] = make_cfg(MODE_DMR, 1, 2);
    cfg_list[2] = make_cfg(MODE_DMR, 2, 0);
    cfg_list[3] = make_cfg(MODE_SINGLE, 0, 1);
    cfg_list[4] = make_cfg(MODE_TMR, 2, 1);
    cfg_list[5] = make_cfg(MODE_DMR, 0, 1);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n    <= 1'b1;
    checking = 1'b1;
    run_random(RAND_CYCLES);
    for (int i = 0; i < NUM_CFG; i++) begin
      // First attempt with some harts awake must not switch
      drain_memory();
      apply_config(cfg_list[i], 1'b0);
      run_random(SHORT_CYCLES);
      drain_memory();
      apply_config(cfg_list[i], 1'b1);
      run_random(RAND_CYCLES);
    end
    drain_memory();
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/safe_pkg.sv
verilog/safe_mode_ctrl.sv
verilog/tmr_voter.sv
verilog/dmr_comparator.sv
verilog/bus_isolator.sv
verilog/bus_router.sv
verilog/safe_bus_wrapper.sv
tests/tb_safe_bus_wrapper.sv

// ==== Bender.yml ====
package:
  name: safe_bus_wrapper

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/safe_pkg.sv
      - verilog/safe_mode_ctrl.sv
      - verilog/tmr_voter.sv
      - verilog/dmr_comparator.sv
      - verilog/bus_isolator.sv
      - verilog/bus_router.sv
      - verilog/safe_bus_wrapper.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_safe_bus_wrapper.sv
